// File: files.f
+incdir+.
core_pkg.sv
inst_decode.sv
alu_execute.sv
lsu_result.sv
data_ram.sv
reg_file.sv
core_top.sv
tb_clock.sv
core_asserts.sv
core_tb.sv

// File: Bender.yml
package:
  name: rv32i_lsu_core

export_include_dirs:
  - .

sources:
  - core_pkg.sv
  - inst_decode.sv
  - alu_execute.sv
  - lsu_result.sv
  - data_ram.sv
  - reg_file.sv
  - core_top.sv
  - target: test
    files:
      - tb_clock.sv
      - core_asserts.sv
      - core_tb.sv

// File: core_tb.sv
`timescale 1ns/1ps
`include "core_cfg.svh"

module core_tb;

    // instruction counts per phase, they set the cycle budget
    localparam int NUM_DIRECTED = 40;
    localparam int NUM_SETUP    = 2 * (`NREGS - 1) + `DMEM_WORDS;
    localparam int NUM_RANDOM   = 400;
    localparam int NUM_INSTS    = NUM_DIRECTED + NUM_SETUP + NUM_RANDOM;
    localparam int CYCLE_LIMIT  = 16 + 3 * NUM_INSTS + 50;
    localparam int AW           = $clog2(`DMEM_WORDS);

    // what one retire should look like
    typedef struct packed {
        logic             we;
        logic [4:0]       rd;
        logic [`XLEN-1:0] data;
        logic             ill;
        logic             has_data;
    } retire_t;

    logic             clk;
    logic             reset;
    logic             inst_valid;
    logic [`XLEN-1:0] inst;
    logic             ready;
    logic             retire;
    logic             retire_we;
    logic             illegal;
    logic [4:0]       retire_rd;
    logic [`XLEN-1:0] retire_data;

    // reference model state
    logic [`XLEN-1:0] model_regs [`NREGS];
    logic [`XLEN-1:0] model_mem [`DMEM_WORDS];
    retire_t          expect_q [$];
    logic [31:0]      lfsr_state;
    int               cycle_count;

    tb_clock u_clock (
        .clk (clk)
    );

    core_top dut (
        .clk         (clk),
        .reset       (reset),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .ready       (ready),
        .retire      (retire),
        .retire_we   (retire_we),
        .illegal     (illegal),
        .retire_rd   (retire_rd),
        .retire_data (retire_data)
    );

    task automatic fail_run();
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
        fail_run();
    endtask

    // galois lfsr, one step per bit handed out
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lfsr_state[0] ? 32'h80200003 : 32'h0);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] sign_extend(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    function automatic retire_t retire_entry(input logic we, input logic [4:0] rd,
                                             input logic [31:0] data, input logic ill,
                                             input logic has_data);
        retire_t e;
        e.we       = we;
        e.rd       = rd;
        e.data     = data;
        e.ill      = ill;
        e.has_data = has_data;
        return e;
    endfunction

    // rv32i field layouts
    function automatic logic [31:0] i_format(input logic [6:0] opc, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_format(input logic [2:0] f3, input logic [4:0] rs1,
                                             input logic [4:0] rs2, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    task automatic write_model(input logic [4:0] rd, input logic [31:0] v);
        // x0 stays zero
        if (rd != 5'd0) begin
            model_regs[rd] = v;
        end
    endtask

    // wait for ready, present one word for one edge
    task automatic issue(input logic [31:0] word, input retire_t exp);
        while (ready !== 1'b1) begin
            @(posedge clk);
            #2;
        end
        expect_q.push_back(exp);
        inst_valid = 1'b1;
        inst       = word;
        @(posedge clk);
        #2;
        inst_valid = 1'b0;
    endtask

    task automatic add_rr(input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
        logic [31:0] sum;
        sum = model_regs[rs1] + model_regs[rs2];
        issue({7'b0, rs2, rs1, 3'b000, rd, 7'b0110011},
              retire_entry(rd != 5'd0, rd, sum, 1'b0, 1'b1));
        write_model(rd, sum);
    endtask

    task automatic add_ri(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
        logic [31:0] sum;
        sum = model_regs[rs1] + sign_extend(imm);
        issue(i_format(7'b0010011, 3'b000, rd, rs1, imm),
              retire_entry(rd != 5'd0, rd, sum, 1'b0, 1'b1));
        write_model(rd, sum);
    endtask

    task automatic load_upper(input logic [4:0] rd, input logic [19:0] imm);
        issue({imm, rd, 7'b0110111}, retire_entry(rd != 5'd0, rd, {imm, 12'b0}, 1'b0, 1'b1));
        write_model(rd, {imm, 12'b0});
    endtask

    // word load ignores bits 1:0, byte load zero-extends
    task automatic load_mem(input logic is_byte, input logic [4:0] rd, input logic [4:0] rs1,
                            input logic [11:0] imm);
        logic [31:0] addr;
        logic [31:0] word;
        logic [31:0] data;
        addr = model_regs[rs1] + sign_extend(imm);
        word = model_mem[addr[AW+1:2]];
        data = is_byte ? {24'b0, word[8*addr[1:0] +: 8]} : word;
        issue(i_format(7'b0000011, is_byte ? 3'b100 : 3'b010, rd, rs1, imm),
              retire_entry(rd != 5'd0, rd, data, 1'b0, 1'b1));
        write_model(rd, data);
    endtask

    task automatic store_mem(input logic is_byte, input logic [4:0] rs1, input logic [4:0] rs2,
                             input logic [11:0] imm);
        logic [31:0] addr;
        addr = model_regs[rs1] + sign_extend(imm);
        issue(s_format(is_byte ? 3'b000 : 3'b010, rs1, rs2, imm),
              retire_entry(1'b0, 5'd0, '0, 1'b0, 1'b0));
        if (is_byte) begin
            model_mem[addr[AW+1:2]][8*addr[1:0] +: 8] = model_regs[rs2][7:0];
        end else begin
            model_mem[addr[AW+1:2]] = model_regs[rs2];
        end
    endtask

    // model untouched
    task automatic send_illegal(input logic [31:0] word);
        issue(word, retire_entry(1'b0, 5'd0, '0, 1'b1, 1'b0));
    endtask

    task automatic arith_basics();
        load_upper(5'd1, 20'h12345);
        add_ri(5'd1, 5'd1, 12'h678);
        add_ri(5'd2, 5'd0, 12'hfff);
        add_rr(5'd3, 5'd1, 5'd2);
        add_ri(5'd5, 5'd3, 12'h7ff);
    endtask

    task automatic word_roundtrip();
        store_mem(1'b0, 5'd0, 5'd1, 12'h040);
        load_mem(1'b0, 5'd6, 5'd0, 12'h040);
        store_mem(1'b0, 5'd0, 5'd3, 12'h044);
        // low address bits dropped on word access
        load_mem(1'b0, 5'd7, 5'd0, 12'h047);
    endtask

    task automatic byte_lanes();
        store_mem(1'b0, 5'd0, 5'd2, 12'h080);
        // one lane at a time, merged word read back each time
        for (int k = 0; k < 4; k++) begin
            add_ri(5'd8, 5'd0, 12'(12'h3c0 + 17 * k));
            store_mem(1'b1, 5'd0, 5'd8, 12'(128 + k));
            load_mem(1'b0, 5'd9, 5'd0, 12'h080);
        end
        for (int k = 0; k < 4; k++) begin
            load_mem(1'b1, 5'd10, 5'd0, 12'(128 + k));
        end
        // byte address through a base register
        add_ri(5'd11, 5'd0, 12'h07c);
        load_mem(1'b1, 5'd12, 5'd11, 12'h005);
    endtask

    task automatic zero_register();
        add_rr(5'd0, 5'd1, 5'd1);
        add_ri(5'd0, 5'd0, 12'h005);
        load_mem(1'b0, 5'd0, 5'd0, 12'h040);
        add_rr(5'd13, 5'd0, 5'd1);
    endtask

    task automatic bad_encodings();
        // sub, branch, lh, sh, all zeros, all ones
        send_illegal({7'b0100000, 5'd2, 5'd1, 3'b000, 5'd4, 7'b0110011});
        send_illegal(i_format(7'b1100011, 3'b000, 5'd0, 5'd1, 12'h000));
        send_illegal(i_format(7'b0000011, 3'b001, 5'd4, 5'd0, 12'h040));
        send_illegal(s_format(3'b001, 5'd0, 5'd2, 12'h040));
        send_illegal(32'h0000_0000);
        send_illegal(32'hffff_ffff);
        // x4 and word 0x40 must be untouched
        add_rr(5'd15, 5'd4, 5'd1);
        load_mem(1'b0, 5'd16, 5'd0, 12'h040);
    endtask

    // every register random, every RAM word written once
    task automatic seed_state();
        for (int r = 1; r < `NREGS; r++) begin
            load_upper(5'(r), 20'(rand_bits(20)));
            add_ri(5'(r), 5'(r), 12'(rand_bits(12)));
        end
        for (int w = 0; w < `DMEM_WORDS; w++) begin
            store_mem(1'b0, 5'd0, 5'(1 + rand_bits(5) % 31), 12'(4 * w));
        end
    endtask

    task automatic random_mix();
        logic [2:0]  kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        for (int n = 0; n < NUM_RANDOM; n++) begin
            kind = 3'(rand_bits(3));
            rd   = 5'(rand_bits(5));
            rs1  = 5'(rand_bits(5));
            rs2  = 5'(rand_bits(5));
            imm  = 12'(rand_bits(12));
            case (kind)
                3'd1:    add_ri(rd, rs1, imm);
                3'd2:    load_upper(rd, 20'(rand_bits(20)));
                3'd3:    load_mem(1'b0, rd, rs1, imm);
                3'd4:    load_mem(1'b1, rd, rs1, imm);
                3'd5:    store_mem(1'b0, rs1, rs2, imm);
                3'd6:    store_mem(1'b1, rs1, rs2, imm);
                default: add_rr(rd, rs1, rs2);
            endcase
        end
    endtask

    // cycle budget
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, core stopped retiring", cycle_count);
            fail_run();
        end
    end

    // compare each retire against the oldest expected entry
    always @(negedge clk) begin
        retire_t exp;
        if (dut.u_asserts.fail_count != 0) begin
            $display("a bound timing check on the core failed");
            fail_run();
        end else if (!reset && retire === 1'b1) begin
            if (expect_q.size() == 0) begin
                $display("retire pulsed with no instruction outstanding");
                fail_run();
            end else begin
                exp = expect_q.pop_front();
                assert (retire_we === exp.we)
                    else report_mismatch("retire_we", 32'(retire_we), 32'(exp.we));
                assert (illegal === exp.ill)
                    else report_mismatch("illegal", 32'(illegal), 32'(exp.ill));
                // payload only for register-writing ops
                if (exp.has_data) begin
                    assert (retire_rd === exp.rd)
                        else report_mismatch("retire_rd", 32'(retire_rd), 32'(exp.rd));
                    assert (retire_data === exp.data)
                        else report_mismatch("retire_data", retire_data, exp.data);
                end
            end
        end
    end

    initial begin
        reset       = 1'b1;
        inst_valid  = 1'b0;
        inst        = '0;
        cycle_count = 0;
        lfsr_state  = 32'h781e;
        for (int r = 0; r < `NREGS; r++) begin
            model_regs[r] = '0;
        end
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;
        assert (ready === 1'b1 && retire === 1'b0)
            else begin
                $display("core not idle after reset");
                fail_run();
            end
        arith_basics();
        word_roundtrip();
        byte_lanes();
        zero_register();
        bad_encodings();
        seed_state();
        random_mix();
        // drain the last retire
        while (expect_q.size() != 0) begin
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        if (dut.u_asserts.fail_count == 0 && ready === 1'b1) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("core did not return to idle, or a timing check failed");
            fail_run();
        end
    end

endmodule

// File: core_asserts.sv
`timescale 1ns/1ps

module core_asserts (
    input logic          clk,
    input logic          reset,
    input logic          inst_valid,
    input logic          ready,
    input logic          retire,
    input logic          retire_we,
    input logic          illegal,
    input core_pkg::op_e op
);
    import core_pkg::*;

    // number of failed checks so far
    int   fail_count = 0;
    logic accept;
    logic short_op;

    assign accept   = ready && inst_valid;
    // all but loads finish in exec
    assign short_op = (op != OP_LW) && (op != OP_LBU);

    // idle and quiet after any reset cycle
    a_reset_idle: assert property (@(posedge clk)
        reset |=> ready && !retire && !retire_we && !illegal)
        else begin
            $error("core not idle after reset");
            fail_count++;
        end

    // accepted instruction takes ready away
    a_busy: assert property (@(posedge clk) disable iff (reset)
        accept |=> !ready)
        else begin
            $error("ready still high after acceptance");
            fail_count++;
        end

    // alu, store and illegal retire one cycle after acceptance
    a_short_retire: assert property (@(posedge clk) disable iff (reset)
        accept ##1 short_op |=> retire && ready)
        else begin
            $error("single cycle instruction did not retire on time");
            fail_count++;
        end

    // loads retire two cycles after acceptance
    a_load_retire: assert property (@(posedge clk) disable iff (reset)
        accept ##1 !short_op |=> (!retire && !ready) ##1 (retire && ready))
        else begin
            $error("load did not retire two cycles after acceptance");
            fail_count++;
        end

    // every retire traces back to an acceptance two or three edges earlier
    a_retire_cause: assert property (@(posedge clk) disable iff (reset)
        retire |-> $past(accept, 2) || $past(accept, 3))
        else begin
            $error("retire without a prior acceptance");
            fail_count++;
        end

    // illegal only on a retire and never with a write
    a_illegal_quiet: assert property (@(posedge clk) disable iff (reset)
        illegal |-> retire && !retire_we)
        else begin
            $error("illegal flag outside a clean retire");
            fail_count++;
        end

endmodule

bind core_top core_asserts u_asserts (
    .clk        (clk),
    .reset      (reset),
    .inst_valid (inst_valid),
    .ready      (ready),
    .retire     (retire),
    .retire_we  (retire_we),
    .illegal    (illegal),
    .op         (op)
);

// File: tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    // 20 ns period, even duty cycle
    initial begin
        clk = 1'b0;
    end

    always #10 clk = ~clk;

endmodule

// File: core_top.sv
`timescale 1ns/1ps
`include "core_cfg.svh"

module core_top (
    input  logic             clk,
    input  logic             reset,
    input  logic             inst_valid,
    input  logic [`XLEN-1:0] inst,
    output logic             ready,
    output logic             retire,
    output logic             retire_we,
    output logic             illegal,
    output logic [4:0]       retire_rd,
    output logic [`XLEN-1:0] retire_data
);
    import core_pkg::*;

    state_e           state;
    logic [`XLEN-1:0] inst_q;
    logic [1:0]       load_offset;
    op_e              op;
    logic [4:0]       rd;
    logic [4:0]       rs1;
    logic [4:0]       rs2;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;
    logic [`XLEN-1:0] alu_result;
    logic [`XLEN-1:0] mem_addr;
    logic [`XLEN-1:0] mem_wdata;
    logic [`XLEN-1:0] mem_rdata;
    logic [`XLEN-1:0] wb_data;
    logic [3:0]       mem_wstrb;
    logic [3:0]       ram_wstrb;
    logic             mem_re;
    logic             ram_re;
    logic             is_load;
    logic             rf_we;
    logic             done;

    assign is_load = (op == OP_LW) || (op == OP_LBU);

    // ALU results go back in exec, loads one state later
    assign rf_we = ((state == ST_EXEC) && (op == OP_ADD || op == OP_ADDI || op == OP_LUI))
                || (state == ST_LOAD);

    // last cycle of every instruction
    assign done = ((state == ST_EXEC) && !is_load) || (state == ST_LOAD);

    // memory only touched in exec
    // the held instruction must not rewrite the RAM while idle
    assign ram_wstrb = (state == ST_EXEC) ? mem_wstrb : 4'b0000;
    assign ram_re    = (state == ST_EXEC) && mem_re;

    assign ready = (state == ST_IDLE);

    // control FSM
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: if (inst_valid) state <= ST_EXEC;
                ST_EXEC: state <= is_load ? ST_LOAD : ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    // instruction register, loaded on acceptance only
    always_ff @(posedge clk) begin
        if (ready && inst_valid) begin
            inst_q <= inst;
        end
    end

    // byte lane of the load, kept for the extract after the read
    always_ff @(posedge clk) begin
        if (state == ST_EXEC) begin
            load_offset <= alu_result[1:0];
        end
    end

    // retire strobe and flags
    always_ff @(posedge clk) begin
        if (reset) begin
            retire    <= 1'b0;
            retire_we <= 1'b0;
            illegal   <= 1'b0;
        end else begin
            retire    <= done;
            retire_we <= rf_we && (rd != 5'd0);
            illegal   <= (state == ST_EXEC) && (op == OP_ILLEGAL);
        end
    end

    // retire payload, only meaningful with retire
    always_ff @(posedge clk) begin
        retire_rd   <= rd;
        retire_data <= wb_data;
    end

    inst_decode u_decode (
        .inst (inst_q),
        .op   (op),
        .rd   (rd),
        .rs1  (rs1),
        .rs2  (rs2),
        .imm  (imm)
    );

    alu_execute u_alu (
        .op         (op),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .imm        (imm),
        .alu_result (alu_result)
    );

    lsu_result u_lsu (
        .op          (op),
        .alu_result  (alu_result),
        .store_data  (rs2_data),
        .mem_rdata   (mem_rdata),
        .load_offset (load_offset),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_wstrb   (mem_wstrb),
        .mem_re      (mem_re),
        .wb_data     (wb_data)
    );

    data_ram u_ram (
        .clk       (clk),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_wstrb (ram_wstrb),
        .mem_re    (ram_re),
        .mem_rdata (mem_rdata)
    );

    reg_file u_rf (
        .clk      (clk),
        .reset    (reset),
        .rs1      (rs1),
        .rs2      (rs2),
        .we       (rf_we),
        .rd       (rd),
        .wd       (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

endmodule

// File: reg_file.sv
`timescale 1ns/1ps
`include "core_cfg.svh"

module reg_file (
    input  logic             clk,
    input  logic             reset,
    input  logic [4:0]       rs1,
    input  logic [4:0]       rs2,
    input  logic             we,
    input  logic [4:0]       rd,
    input  logic [`XLEN-1:0] wd,
    output logic [`XLEN-1:0] rs1_data,
    output logic [`XLEN-1:0] rs2_data
);

    logic [`XLEN-1:0] regs [`NREGS];

    // single write port, cleared on reset
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin
            // x0 writes dropped
            regs[rd] <= wd;
        end
    end

    // two combinational read ports
    // x0 forced to zero
    assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// File: data_ram.sv
`timescale 1ns/1ps
`include "core_cfg.svh"

module data_ram (
    input  logic             clk,
    input  logic [`XLEN-1:0] mem_addr,
    input  logic [`XLEN-1:0] mem_wdata,
    input  logic [3:0]       mem_wstrb,
    input  logic             mem_re,
    output logic [`XLEN-1:0] mem_rdata
);

    // word index width
    localparam int AW = $clog2(`DMEM_WORDS);

    logic [`XLEN-1:0] mem [`DMEM_WORDS];
    logic [AW-1:0]    word_idx;

    // byte address to word index
    // upper bits dropped, so accesses wrap
    assign word_idx = mem_addr[AW+1:2];

    // byte-lane writes
    always_ff @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (mem_wstrb[b]) begin
                mem[word_idx][8*b +: 8] <= mem_wdata[8*b +: 8];
            end
        end
    end

    // registered read, one cycle latency
    // holds its value while no read is requested
    always_ff @(posedge clk) begin
        if (mem_re) begin
            mem_rdata <= mem[word_idx];
        end
    end

endmodule

// File: lsu_result.sv
`timescale 1ns/1ps
`include "core_cfg.svh"

module lsu_result (
    input  core_pkg::op_e    op,
    input  logic [`XLEN-1:0] alu_result,
    input  logic [`XLEN-1:0] store_data,
    input  logic [`XLEN-1:0] mem_rdata,
    input  logic [1:0]       load_offset,
    output logic [`XLEN-1:0] mem_addr,
    output logic [`XLEN-1:0] mem_wdata,
    output logic [3:0]       mem_wstrb,
    output logic             mem_re,
    output logic [`XLEN-1:0] wb_data
);
    import core_pkg::*;

    logic [1:0]       store_offset;
    logic [`XLEN-1:0] byte_wdata;
    logic [3:0]       byte_wstrb;
    logic [7:0]       load_byte;

    // address straight from the adder
    // the RAM ignores bits 1:0 on its word index
    assign mem_addr     = alu_result;
    assign store_offset = alu_result[1:0];

    // byte store lane shift
    // data moves up by 8 x offset, one strobe per lane
    always_comb begin
        case (store_offset)
            2'b00: begin
                byte_wdata = store_data;
                byte_wstrb = 4'b0001;
            end
            2'b01: begin
                byte_wdata = {store_data[23:0], 8'b0};
                byte_wstrb = 4'b0010;
            end
            2'b10: begin
                byte_wdata = {store_data[15:0], 16'b0};
                byte_wstrb = 4'b0100;
            end
            2'b11: begin
                byte_wdata = {store_data[7:0], 24'b0};
                byte_wstrb = 4'b1000;
            end
            default: begin
                byte_wdata = store_data;
                byte_wstrb = 4'b0000;
            end
        endcase
    end

    // store path
    always_comb begin
        case (op)
            OP_SW: begin
                // whole word, no shift
                mem_wdata = store_data;
                mem_wstrb = 4'b1111;
            end
            OP_SB: begin
                mem_wdata = byte_wdata;
                mem_wstrb = byte_wstrb;
            end
            default: begin
                mem_wdata = store_data;
                mem_wstrb = 4'b0000;
            end
        endcase
    end

    // read request for both load types
    assign mem_re = (op == OP_LW) || (op == OP_LBU);

    // byte pick uses the offset held since the read was issued
    always_comb begin
        case (load_offset)
            2'b00:   load_byte = mem_rdata[7:0];
            2'b01:   load_byte = mem_rdata[15:8];
            2'b10:   load_byte = mem_rdata[23:16];
            default: load_byte = mem_rdata[31:24];
        endcase
    end

    // writeback select
    always_comb begin
        case (op)
            OP_LW:   wb_data = mem_rdata;
            // zero extension only, signed loads not kept
            OP_LBU:  wb_data = {{(`XLEN-8){1'b0}}, load_byte};
            default: wb_data = alu_result;
        endcase
    end

endmodule

// File: alu_execute.sv
`timescale 1ns/1ps
`include "core_cfg.svh"

module alu_execute (
    input  core_pkg::op_e    op,
    input  logic [`XLEN-1:0] rs1_data,
    input  logic [`XLEN-1:0] rs2_data,
    input  logic [`XLEN-1:0] imm,
    output logic [`XLEN-1:0] alu_result
);
    import core_pkg::*;

    logic [`XLEN-1:0] operand_b;
    logic [`XLEN-1:0] sum;

    // second adder input
    // register for add, immediate for addi and address generation
    always_comb begin
        case (op)
            OP_ADD:  operand_b = rs2_data;
            default: operand_b = imm;
        endcase
    end

    // one shared adder serves arithmetic and addresses
    assign sum = rs1_data + operand_b;

    // result select
    always_comb begin
        case (op)
            OP_ADD,
            OP_ADDI: begin
                alu_result = sum;
            end
            OP_LW,
            OP_LBU,
            OP_SW,
            OP_SB: begin
                // effective address, offsets are sign-extended by decode
                alu_result = sum;
            end
            OP_LUI: begin
                // immediate already sits in the upper bits
                alu_result = imm;
            end
            default: begin
                // illegal, nothing is written back
                alu_result = '0;
            end
        endcase
    end

endmodule

// File: inst_decode.sv
`timescale 1ns/1ps
`include "core_cfg.svh"

module inst_decode (
    input  logic [`XLEN-1:0] inst,
    output core_pkg::op_e    op,
    output logic [4:0]       rd,
    output logic [4:0]       rs1,
    output logic [4:0]       rs2,
    output logic [`XLEN-1:0] imm
);
    import core_pkg::*;

    // major opcodes of the kept RV32I subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    // fixed field positions
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rd     = inst[11:7];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    // opcode, funct3 and funct7 to op_e
    always_comb begin
        op = OP_ILLEGAL;
        case (opcode)
            OPC_OP: begin
                // only plain add, sub and friends stay illegal
                if (funct3 == 3'b000 && funct7 == 7'b0000000) begin
                    op = OP_ADD;
                end
            end
            OPC_OP_IMM: begin
                if (funct3 == 3'b000) begin
                    op = OP_ADDI;
                end
            end
            OPC_LUI: op = OP_LUI;
            OPC_LOAD: begin
                // word and unsigned byte only
                if (funct3 == 3'b010) begin
                    op = OP_LW;
                end else if (funct3 == 3'b100) begin
                    op = OP_LBU;
                end
            end
            OPC_STORE: begin
                if (funct3 == 3'b010) begin
                    op = OP_SW;
                end else if (funct3 == 3'b000) begin
                    op = OP_SB;
                end
            end
            default: op = OP_ILLEGAL;
        endcase
    end

    // immediate format follows the opcode
    always_comb begin
        case (opcode)
            // s-type, split field
            OPC_STORE: imm = {{(`XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
            // u-type, upper 20 bits
            OPC_LUI:   imm = {inst[31:12], 12'b0};
            // i-type for addi and loads
            default:   imm = {{(`XLEN-12){inst[31]}}, inst[31:20]};
        endcase
    end

endmodule

// File: core_pkg.sv
package core_pkg;

    // decoded operation, one code per supported instruction
    // anything the decoder does not recognise maps to OP_ILLEGAL
    typedef enum logic [2:0] {
        OP_ADD,
        OP_ADDI,
        OP_LUI,
        OP_LW,
        OP_LBU,
        OP_SW,
        OP_SB,
        OP_ILLEGAL
    } op_e;

    // control states of the core
    // idle waits for an instruction
    // exec does ALU writeback, store, or load read issue
    // load writes the loaded value back
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_EXEC,
        ST_LOAD
    } state_e;

endpackage

// File: core_cfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// datapath and address width
`define XLEN 32

// architectural integer registers, x0 included
`define NREGS 32

// data RAM depth in 32-bit words
// higher address bits wrap onto these entries
`define DMEM_WORDS 256

`endif
